/* design/decodePkg.sv */
// Widths, opcode and condition codes and control types shared by every block of the decode stage
`default_nettype none

package decodePkg;

   localparam int dataWidth    = 16;   // Data words, register contents and PC values
   localparam int regAddrWidth = 3;    // Enough to name r0 through r7
   localparam int numRegs      = 8;    // General registers in the register file

   // Major opcode of the conditional branch group (BEQZ, BNEZ, BLTZ, BGEZ)
   localparam logic [2:0] opBranch = 3'b011;

   // Branch conditions as encoded in bits 12:11 of a branch instruction
   localparam logic [1:0] condEqz = 2'b00;   // Taken when rs equals zero
   localparam logic [1:0] condNez = 2'b01;   // Taken when rs is not zero
   localparam logic [1:0] condLtz = 2'b10;   // Taken when rs is negative
   localparam logic [1:0] condGez = 2'b11;   // Taken when rs is zero or positive

   typedef logic [regAddrWidth-1:0] regAddrT;   // Register index
   typedef logic [dataWidth-1:0]    dataT;      // One data word

   // The instruction word in decode is read two ways
   // Both views place rs in bits 10:8 so read port 1 needs no mux
   typedef union packed {
      struct packed {
         logic [4:0] opcode;   // Full five-bit opcode
         regAddrT    rs;       // First source, goes to read port 1
         regAddrT    rt;       // Second source, goes to read port 2
         logic [4:0] tail;     // Rd and function bits, decoded outside this stage
      } regForm;
      struct packed {
         logic [2:0] group;    // Equals opBranch for the conditional branches
         logic [1:0] cond;     // One of the four cond codes above
         regAddrT    rs;       // Register that is tested
         logic [7:0] disp;     // Displacement, extended by the immediate logic
      } branchForm;
   } instrWordT;

   // Controls of the register write port, produced by the writeback side
   typedef struct packed {
      logic    en;     // Store writeData at the next rising edge
      logic    lbi;    // Load-byte-immediate takes imm as write data
      logic    link;   // Jump-and-link takes the return address as write data
      regAddrT addr;   // Destination register
   } writeCtrlT;

   // Flow controls from the main decoder
   typedef struct packed {
      logic bFlag;   // Treat the instruction as a branch even outside the group
      logic jFlag;   // Unconditional jump request
      logic halt;    // Processor is halting, never redirect the PC
   } flowCtrlT;

endpackage

`default_nettype wire

/* design/regFile.sv */
// Eight-entry register file that serves both read ports of the decode stage and takes one write per clock
`default_nettype none

module regFile (
   input  wire                logic clk,
   input  wire                logic arstN,
   input  decodePkg::regAddrT rdAddr1,     // Usually rs
   input  decodePkg::regAddrT rdAddr2,     // Usually rt
   input  wire                logic wrEn,
   input  decodePkg::regAddrT wrAddr,
   input  decodePkg::dataT    writeData,
   output decodePkg::dataT    rdData1,
   output decodePkg::dataT    rdData2
);

   import decodePkg::*;

   dataT regs [numRegs];   // r0 is an ordinary register here, not hardwired to zero

   // Both reads are plain array lookups with no bypass
   // A write in this cycle becomes visible only after the edge
   assign rdData1 = regs[rdAddr1];
   assign rdData2 = regs[rdAddr2];

   // Whole file clears on reset so reads after reset are defined
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= writeData;   // Single write port, one register per cycle
      end
   end

endmodule

`default_nettype wire

/* design/writeDataSelect.sv */
// Picks the register write data from writeback, the immediate or the link return address
`default_nettype none

module writeDataSelect (
   input  wire             logic clk,
   input  wire             logic arstN,
   input  decodePkg::dataT pc,          // Fetch PC, one instruction ahead of decode
   input  decodePkg::dataT imm,         // Already extended immediate
   input  decodePkg::dataT writeback,   // Result from the writeback stage
   input  wire             logic lbi,
   input  wire             logic link,
   output decodePkg::dataT writeData
);

   import decodePkg::*;

   dataT pcInstr;      // PC of the instruction now in decode
   dataT returnAddr;   // Address of the instruction after it

   // Fetch has already moved on, so the PC of the decoded instruction
   // is what fetch showed at the previous edge
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pcInstr <= '0;
      end else begin
         pcInstr <= pc;
      end
   end

   assign returnAddr = pcInstr + dataT'(2);   // Instructions are two bytes wide

   // Link has priority over lbi, writeback is the default source
   always_comb begin
      if (link) begin
         writeData = returnAddr;
      end else if (lbi) begin
         writeData = imm;
      end else begin
         writeData = writeback;
      end
   end

endmodule

`default_nettype wire

/* design/branchResolve.sv */
// Resolves the zero and sign branches and the jump request into the PC-select level for fetch
`default_nettype none

module branchResolve (
   input  decodePkg::instrWordT instr,
   input  decodePkg::dataT      rsData,   // Contents of rs from read port 1
   input  decodePkg::flowCtrlT  flow,
   output logic                 pcSel     // High to take the branch or jump target
);

   import decodePkg::*;

   logic zeroFlag;
   logic signFlag;
   logic taken;          // Outcome of the condition alone
   logic branchApplies;  // Instruction counts as a branch or jump

   assign zeroFlag = (rsData == '0);
   assign signFlag = rsData[dataWidth-1];   // Two's complement sign bit

   // The condition field is only meaningful for branches, the gating below
   // keeps it from mattering for anything else
   always_comb begin
      case (instr.branchForm.cond)
         condEqz: taken = zeroFlag;    // BEQZ
         condNez: taken = !zeroFlag;   // BNEZ
         condLtz: taken = signFlag;    // BLTZ
         condGez: taken = !signFlag;   // BGEZ
         default: taken = 1'b0;
      endcase
   end

   // The decoder may flag jumps through bFlag even though their opcode
   // lies outside the branch group
   assign branchApplies = (instr.branchForm.group == opBranch) || flow.bFlag;

   // Halt wins over everything so a halting core never redirects
   assign pcSel = branchApplies && !flow.halt && (taken || flow.jFlag);

endmodule

`default_nettype wire

/* design/decodeStage.sv */
// Top level of the decode stage that joins the register file, write data select and branch logic
`default_nettype none

module decodeStage (
   input  wire                  logic clk,
   input  wire                  logic arstN,
   input  decodePkg::instrWordT instr,       // Instruction held in decode
   input  decodePkg::dataT      imm,         // Extended immediate for lbi
   input  decodePkg::dataT      writeback,   // Value returning from writeback
   input  decodePkg::dataT      pc,          // Current fetch PC
   input  decodePkg::writeCtrlT wrCtrl,      // Register write controls
   input  decodePkg::flowCtrlT  flow,        // Branch, jump and halt controls
   output decodePkg::dataT      reg1Data,
   output decodePkg::dataT      reg2Data,
   output logic                 pcSel
);

   import decodePkg::*;

   regAddrT rs;          // First source register
   regAddrT rt;          // Second source register
   dataT    writeData;   // Data for the register write port

   // Register fields come from the ALU view of the word
   assign rs = instr.regForm.rs;
   assign rt = instr.regForm.rt;

   writeDataSelect uWriteDataSelect (
      .clk       (clk),
      .arstN     (arstN),
      .pc        (pc),
      .imm       (imm),
      .writeback (writeback),
      .lbi       (wrCtrl.lbi),
      .link      (wrCtrl.link),
      .writeData (writeData)
   );

   regFile uRegFile (
      .clk       (clk),
      .arstN     (arstN),
      .rdAddr1   (rs),
      .rdAddr2   (rt),
      .wrEn      (wrCtrl.en),
      .wrAddr    (wrCtrl.addr),
      .writeData (writeData),
      .rdData1   (reg1Data),
      .rdData2   (reg2Data)
   );

   // Branches test rs, which is what read port 1 already returns
   branchResolve uBranchResolve (
      .instr  (instr),
      .rsData (reg1Data),
      .flow   (flow),
      .pcSel  (pcSel)
   );

endmodule

`default_nettype wire

/* tests/decodeStage_assert.sv */
// Concurrent port checks on the decode stage, bound into every decodeStage instance of the simulation
`default_nettype none

module decodeStageAssert (
   input wire logic                 clk,
   input wire logic                 arstN,
   input wire decodePkg::instrWordT instr,
   input wire decodePkg::flowCtrlT  flow,
   input wire decodePkg::dataT      reg1Data,
   input wire logic                 pcSel
);

   timeunit 1ns;
   timeprecision 1ps;

   import decodePkg::*;

   int assertFailures = 0;   // Read by the testbench when it sums up the run

   // A halting core must never redirect fetch
   haltBlocksPcSel: assert property (@(posedge clk) disable iff (!arstN)
      flow.halt |-> !pcSel)
      else begin
         $error("pcSel is high while halt is set");
         assertFailures++;
      end

   // Outside the branch group and with no flow request there is nothing to take
   noBranchNoPcSel: assert property (@(posedge clk) disable iff (!arstN)
      (instr.branchForm.group != opBranch && !flow.bFlag && !flow.jFlag) |-> !pcSel)
      else begin
         $error("pcSel is high for an instruction that is neither branch nor jump");
         assertFailures++;
      end

   // Register file is held clear for as long as reset is asserted
   resetClearsRead: assert property (@(posedge clk)
      !arstN |-> reg1Data == '0)
      else begin
         $error("reg1Data is not zero during reset");
         assertFailures++;
      end

endmodule

bind decodeStage decodeStageAssert uDecodeStageAssert (
   .clk      (clk),
   .arstN    (arstN),
   .instr    (instr),
   .flow     (flow),
   .reg1Data (reg1Data),
   .pcSel    (pcSel)
);

`default_nettype wire

/* tests/decodeStageTb.sv */
// Self-checking testbench for the decode stage, random stimulus checked against a local model
`default_nettype none

module decodeStageTb;

   timeunit 1ns;
   timeprecision 1ps;

   import decodePkg::*;

   localparam int clkPeriod    = 40;
   localparam int resetCycles  = 10;
   localparam int pairCycles   = numRegs * numRegs;   // Every read-address pair once
   localparam int writeCycles  = 200;
   localparam int selectCycles = 150;
   localparam int branchCycles = 200;
   localparam int jumpCycles   = 200;
   localparam int testCycles   = resetCycles + pairCycles + writeCycles + selectCycles
                                 + branchCycles + jumpCycles;
   localparam int timeoutNs    = testCycles * clkPeriod + 50 * clkPeriod;   // Margin of 50 cycles

   logic      clk;
   logic      arstN;
   instrWordT instr;
   dataT      imm;
   dataT      writeback;
   dataT      pc;
   writeCtrlT wrCtrl;
   flowCtrlT  flow;
   dataT      reg1Data;
   dataT      reg2Data;
   logic      pcSel;

   dataT    modelRegs [numRegs];   // Expected register contents
   dataT    modelPrevPc;           // The pc seen at the last rising edge
   regAddrT prevAddr;              // Write address driven in the cycle before
   int      seed;
   int      errorCount;
   int      checkCount;

   decodeStage u_dut (
      .clk       (clk),
      .arstN     (arstN),
      .instr     (instr),
      .imm       (imm),
      .writeback (writeback),
      .pc        (pc),
      .wrCtrl    (wrCtrl),
      .flow      (flow),
      .reg1Data  (reg1Data),
      .reg2Data  (reg2Data),
      .pcSel     (pcSel)
   );

   initial clk = 1'b0;
   always #(clkPeriod / 2) clk = ~clk;

   // Data words biased toward zero and negative values so all four conditions fire
   function automatic dataT randomData();
      logic [31:0] r;
      r = $random(seed);
      case (r[17:16])
         2'd0:    return '0;
         2'd1:    return {1'b1, r[14:0]};   // Negative
         default: return r[15:0];
      endcase
   endfunction

   // Branch rule: group 011 or bFlag applies, halt blocks, condition or jFlag takes
   function automatic logic expectedPcSel(logic [15:0] word, dataT rsVal, flowCtrlT f);
      logic isBranch;
      logic condMet;
      isBranch = (word[15:13] == opBranch) || f.bFlag;
      case (word[12:11])
         condEqz: condMet = (rsVal == 16'h0000);
         condNez: condMet = (rsVal != 16'h0000);
         condLtz: condMet = rsVal[15];
         default: condMet = !rsVal[15];   // condGez
      endcase
      return isBranch && !f.halt && (condMet || f.jFlag);
   endfunction

   task automatic checkOutputs();
      dataT expReg1;
      dataT expReg2;
      logic expSel;
      expReg1 = modelRegs[instr[10:8]];   // rs field
      expReg2 = modelRegs[instr[7:5]];    // rt field
      expSel  = expectedPcSel(instr, expReg1, flow);
      checkCount++;
      if (reg1Data !== expReg1) begin
         errorCount++;
         $display("FAILED reg1Data: got %h, expected %h at %0t", reg1Data, expReg1, $time);
      end
      if (reg2Data !== expReg2) begin
         errorCount++;
         $display("FAILED reg2Data: got %h, expected %h at %0t", reg2Data, expReg2, $time);
      end
      if (pcSel !== expSel) begin
         errorCount++;
         $display("FAILED pcSel: got %h, expected %h at %0t", pcSel, expSel, $time);
      end
   endtask

   // Mirrors what the DUT stores at the rising edge that just passed
   task automatic updateModel();
      dataT wrData;
      if (wrCtrl.link) begin
         wrData = modelPrevPc + 16'd2;   // Link beats lbi
      end else if (wrCtrl.lbi) begin
         wrData = imm;
      end else begin
         wrData = writeback;
      end
      if (wrCtrl.en) begin
         modelRegs[wrCtrl.addr] = wrData;
      end
      modelPrevPc = pc;
   endtask

   // Called at a falling edge with the inputs already driven
   task automatic runCycle();
      #(clkPeriod / 4);   // Reads are combinational, give them a quarter period
      checkOutputs();
      @(posedge clk);
      updateModel();
      @(negedge clk);   // Next stimulus goes out here
   endtask

   task automatic driveRandom();
      instr     = $random(seed);
      imm       = randomData();
      writeback = randomData();
      pc        = $random(seed);
      wrCtrl    = $random(seed);
      flow      = '0;
   endtask

   initial begin
      seed       = 1;
      errorCount = 0;
      checkCount = 0;
      arstN      = 1'b1;
      instr      = '0;
      imm        = '0;
      writeback  = '0;
      pc         = '0;
      wrCtrl     = '0;
      flow       = '0;
      prevAddr   = '0;
      for (int i = 0; i < numRegs; i++) begin
         modelRegs[i] = '0;
      end
      modelPrevPc = '0;

      // Reset goes low on a real falling edge of the clock
      @(negedge clk);
      arstN = 1'b0;
      for (int i = 0; i < resetCycles; i++) begin
         instr.regForm.rs = i;   // Walk read port 1 over the file while it is held clear
         @(negedge clk);
      end
      arstN = 1'b1;

      // Every pair of registers reads zero straight after reset
      for (int i = 0; i < numRegs; i++) begin
         for (int j = 0; j < numRegs; j++) begin
            instr             = '0;
            instr.regForm.rs  = i;
            instr.regForm.rt  = j;
            runCycle();
         end
      end

      // Plain writeback writes, often reading the register being written
      for (int k = 0; k < writeCycles; k++) begin
         prevAddr = wrCtrl.addr;
         driveRandom();
         wrCtrl.lbi  = 1'b0;
         wrCtrl.link = 1'b0;
         instr.regForm.rt = prevAddr;   // Read back one cycle after the write
         if ($random(seed) & 1) begin
            instr.regForm.rs = wrCtrl.addr;   // Same-cycle read must still see the old value
         end
         runCycle();
      end

      // Write data source selection among writeback, imm and link
      for (int k = 0; k < selectCycles; k++) begin
         prevAddr = wrCtrl.addr;
         driveRandom();
         wrCtrl.en = 1'b1;
         instr.regForm.rt = prevAddr;   // Shows the source picked in the cycle before
         runCycle();
      end

      // Conditional branches, cycling through all four conditions
      for (int k = 0; k < branchCycles; k++) begin
         driveRandom();
         instr.branchForm.group = opBranch;
         instr.branchForm.cond  = k[1:0];
         runCycle();
      end

      // Jumps and random flow controls with halt now and then
      for (int k = 0; k < jumpCycles; k++) begin
         driveRandom();
         flow = $random(seed);
         if (k < jumpCycles / 2) begin
            flow.bFlag = 1'b1;
            flow.jFlag = 1'b1;
         end
         runCycle();
      end

      errorCount += u_dut.uDecodeStageAssert.assertFailures;
      $display("Checks: %0d, errors: %0d (assertion failures: %0d)", checkCount, errorCount,
               u_dut.uDecodeStageAssert.assertFailures);
      if (errorCount == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Watchdog in case the stimulus loop stalls
   initial begin
      #(timeoutNs);
      $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
design/decodePkg.sv
design/regFile.sv
design/writeDataSelect.sv
design/branchResolve.sv
design/decodeStage.sv
tests/decodeStage_assert.sv
tests/decodeStageTb.sv
